//--- exec_top.f
+incdir+sim
verilog/exec_pkg.sv
verilog/exec_decode.sv
verilog/int_alu.sv
verilog/seq_divider.sv
verilog/muldiv_hilo.sv
verilog/exec_writeback.sv
verilog/exec_top.sv
sim/clk_gen.sv
sim/tb_exec_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the execute block testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f exec_top.f \
    --top-module tb_exec_top -Mdir obj_dir -o sim_exec_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_exec_top)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qF 'All tests passed!'; then
    exit 0
fi
exit 1

//--- sim/clk_gen.sv
`timescale 1ns/1ns

module clk_gen #(
    parameter int period       = 8,
    parameter int reset_cycles = 5
) (
    output logic div_ready,
    output logic rst_n
);

    initial begin
        div_ready = 1'b0;
        forever #(period / 2) div_ready = ~div_ready;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge div_ready);
        rst_n <= 1'b1;
    end

endmodule

//--- sim/exec_tests.svh
function automatic logic signed_overflow(input logic [word_w-1:0] x, input logic [word_w-1:0] y,
                                         input bit is_sub);
    longint s;
    s = is_sub ? longint'($signed(x)) - longint'($signed(y))
               : longint'($signed(x)) + longint'($signed(y));
    return s != longint'($signed(s[word_w-1:0]));   // does not fit in one word
endfunction

function automatic logic [hilo_w-1:0] divide_result(input logic [word_w-1:0] x,
                                                    input logic [word_w-1:0] y, input bit sgn);
    logic [word_w-1:0] mx;
    logic [word_w-1:0] my;
    logic [word_w-1:0] q;
    logic [word_w-1:0] r;
    bit                nx;
    bit                ny;
    nx = sgn && x[word_w-1];
    ny = sgn && y[word_w-1];
    mx = nx ? -x : x;
    my = ny ? -y : y;
    if (my == '0) begin
        q = '1;
        r = mx;
    end else begin
        q = mx / my;
        r = mx % my;
    end
    if (nx != ny) q = -q;
    if (nx) r = -r;
    return {r, q};
endfunction

// issue one op, wait for its result and check value, latency, busy and hilo
task automatic run_op(input string name, input alu_op_t o, input logic [word_w-1:0] x,
                      input logic [word_w-1:0] y, input logic [word_w-1:0] exp,
                      input logic exp_ovf);
    int n;
    bit got;
    bit is_div;
    is_div = (o == div) || (o == divu);
    op_valid <= 1'b1;
    op       <= o;
    a        <= x;
    b        <= y;
    @(posedge div_ready);
    op_valid <= 1'b0;
    n   = 0;
    got = 1'b0;
    while (!got && n <= div_latency + 4) begin
        @(posedge div_ready);
        n++;
        got = result_valid;
        if (!got && is_div) check_bit({name, " busy"}, 1'b1, busy);
    end
    if (!got) begin
        $display("%s: result_valid never came after the issue", name);
        other_errs++;
    end else begin
        check_latency(name, is_div ? div_latency : 2, n);
        check_word(name, exp, result);
        check_bit({name, " overflow"}, exp_ovf, overflow);
        check_bit({name, " busy"}, 1'b0, busy);
        check_hilo({name, " hilo"}, model_hilo, hilo);
    end
endtask

task automatic arith_ops();
    logic [word_w-1:0] x;
    logic [word_w-1:0] y;
    for (int i = 0; i < 4; i++) begin
        x = $random(seed);
        y = $random(seed);
        run_op("add rand", add, x, y, x + y, signed_overflow(x, y, 1'b0));
        run_op("sub rand", sub, x, y, x - y, signed_overflow(x, y, 1'b1));
        run_op("addu rand", addu, x, y, x + y, 1'b0);
        run_op("subu rand", subu, x, y, x - y, 1'b0);
    end
    run_op("add max+1", add, 32'h7fffffff, 32'h1, 32'h80000000, 1'b1);
    run_op("add min+min", add, 32'h80000000, 32'h80000000, 32'h0, 1'b1);
    run_op("add -1+1", add, 32'hffffffff, 32'h1, 32'h0, 1'b0);
    run_op("sub min-1", sub, 32'h80000000, 32'h1, 32'h7fffffff, 1'b1);
    run_op("sub max-(-1)", sub, 32'h7fffffff, 32'hffffffff, 32'h80000000, 1'b1);
    run_op("addu max+1", addu, 32'h7fffffff, 32'h1, 32'h80000000, 1'b0);
    run_op("subu min-1", subu, 32'h80000000, 32'h1, 32'h7fffffff, 1'b0);
endtask

task automatic logic_ops();
    logic [word_w-1:0] x;
    logic [word_w-1:0] y;
    for (int i = 0; i < 2; i++) begin
        x = $random(seed);
        y = $random(seed);
        run_op("slt rand", slt, x, y, (int'(x) < int'(y)) ? 32'd1 : 32'd0, 1'b0);
        run_op("sltu rand", sltu, x, y, (x < y) ? 32'd1 : 32'd0, 1'b0);
        run_op("and rand", and_op, x, y, x & y, 1'b0);
        run_op("or rand", or_op, x, y, x | y, 1'b0);
        run_op("nor rand", nor_op, x, y, ~(x | y), 1'b0);
        run_op("xor rand", xor_op, x, y, x ^ y, 1'b0);
        run_op("sll rand", sll, x, y, y << x[shamt_w-1:0], 1'b0);
        run_op("srl rand", srl, x, y, y >> x[shamt_w-1:0], 1'b0);
        run_op("sra rand", sra, x, y | 32'h80000000,
               int'(y | 32'h80000000) >>> x[shamt_w-1:0], 1'b0);   // negative value
    end
    run_op("slt min<1", slt, 32'h80000000, 32'h1, 32'h1, 1'b0);
    run_op("sltu min<1", sltu, 32'h80000000, 32'h1, 32'h0, 1'b0);
    run_op("lui", lui, 32'h0, 32'h1234abcd, 32'habcd0000, 1'b0);
    run_op("sll 31", sll, 32'd31, 32'h1, 32'h80000000, 1'b0);
    run_op("srl 31", srl, 32'd31, 32'h80000000, 32'h1, 1'b0);
    run_op("sra 31", sra, 32'd31, 32'h80000000, 32'hffffffff, 1'b0);
    run_op("sra 0", sra, 32'd0, 32'h80000001, 32'h80000001, 1'b0);
endtask

task automatic mult_pair(input logic [word_w-1:0] x, input logic [word_w-1:0] y);
    model_hilo = longint'($signed(x)) * longint'($signed(y));
    run_op($sformatf("mult %h*%h", x, y), mult, x, y, '0, 1'b0);
    run_op("mfhi after mult", mfhi, '0, '0, model_hilo[hilo_w-1:word_w], 1'b0);
    model_hilo = hilo_w'(x) * hilo_w'(y);
    run_op($sformatf("multu %h*%h", x, y), multu, x, y, '0, 1'b0);
    run_op("mflo after multu", mflo, '0, '0, model_hilo[word_w-1:0], 1'b0);
endtask

task automatic multiply_ops();
    mult_pair(32'hfffffffd, 32'd7);
    mult_pair(32'h80000000, 32'h80000000);
    mult_pair(32'hffffffff, 32'hffffffff);
    mult_pair($random(seed), $random(seed));
endtask

task automatic div_pair(input logic [word_w-1:0] x, input logic [word_w-1:0] y);
    model_hilo = divide_result(x, y, 1'b1);
    run_op($sformatf("div %h/%h", x, y), div, x, y, '0, 1'b0);
    model_hilo = divide_result(x, y, 1'b0);
    run_op($sformatf("divu %h/%h", x, y), divu, x, y, '0, 1'b0);
endtask

task automatic divide_ops();
    div_pair(32'd100, 32'd7);
    div_pair(-32'd100, 32'd7);
    div_pair(32'd100, -32'd7);
    div_pair(-32'd100, -32'd7);
    div_pair(32'd1234, 32'd0);       // zero divisor
    div_pair(-32'd1234, 32'd0);
    div_pair(32'h80000000, 32'hffffffff);
    div_pair($random(seed), $random(seed));
    div_pair($random(seed), 32'd3);
endtask

task automatic move_ops();
    alu_op_t           ops[4];
    logic [word_w-1:0] xs[4];
    logic [word_w-1:0] exps[4];
    int                got;
    cp0_data <= 32'hc0de0001;
    model_hilo[hilo_w-1:word_w] = 32'hdeadbeef;
    run_op("mthi", mthi, 32'hdeadbeef, '0, '0, 1'b0);
    model_hilo[word_w-1:0] = 32'h0badf00d;
    run_op("mtlo", mtlo, 32'h0badf00d, '0, '0, 1'b0);
    run_op("mfc0", mfc0, '0, '0, 32'hc0de0001, 1'b0);

    // one issue per cycle with results back in order
    ops  = '{add, mthi, mfhi, mfc0};
    xs   = '{32'd5, 32'h13579bdf, 32'd0, 32'd0};
    exps = '{32'd14, 32'd0, 32'h13579bdf, 32'hc0de0001};
    model_hilo[hilo_w-1:word_w] = 32'h13579bdf;
    got = 0;
    for (int c = 0; c < 10 && got < 4; c++) begin
        if (c < 4) begin
            op_valid <= 1'b1;
            op       <= ops[c];
            a        <= xs[c];
            b        <= 32'd9;
        end else begin
            op_valid <= 1'b0;
        end
        @(posedge div_ready);
        if (result_valid) begin
            check_latency($sformatf("back-to-back %0d", got), got + 2, c);
            check_word($sformatf("back-to-back %0d", got), exps[got], result);
            got++;
        end
    end
    if (got != 4) begin
        $display("back-to-back: only %0d of 4 results came back", got);
        other_errs++;
    end
    check_hilo("back-to-back hilo", model_hilo, hilo);
endtask

//--- sim/tb_exec_top.sv
`timescale 1ns/1ns

module tb_exec_top import exec_pkg::*; ();

    localparam int num_ops    = 100;   // upper bound on issued operations
    localparam int max_cycles = num_ops * div_latency + 200;

    logic              div_ready;
    logic              rst_n;
    logic              op_valid;
    alu_op_t           op;
    logic [word_w-1:0] a;
    logic [word_w-1:0] b;
    logic [word_w-1:0] cp0_data;
    logic              result_valid;
    logic [word_w-1:0] result;
    logic              overflow;
    logic [hilo_w-1:0] hilo;
    logic              busy;

    int                seed       = 4;
    int                cycles     = 0;
    int                value_errs = 0;
    int                other_errs = 0;
    logic [hilo_w-1:0] model_hilo;   // expected HI/LO pair

    clk_gen #(.period(8), .reset_cycles(5)) clk0 (.div_ready(div_ready), .rst_n(rst_n));

    exec_top #(.div_steps(32)) dut0 (
        .div_ready    (div_ready),
        .rst_n        (rst_n),
        .op_valid     (op_valid),
        .op           (op),
        .a            (a),
        .b            (b),
        .cp0_data     (cp0_data),
        .result_valid (result_valid),
        .result       (result),
        .overflow     (overflow),
        .hilo         (hilo),
        .busy         (busy)
    );

    task automatic check_word(input string name, input logic [word_w-1:0] exp,
                              input logic [word_w-1:0] act);
        if (act !== exp) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_hilo(input string name, input logic [hilo_w-1:0] exp,
                              input logic [hilo_w-1:0] act);
        if (act !== exp) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("ERROR %s latency: expected %0d, actual %0d", name, exp, act);
            value_errs++;
        end
    endtask

    `include "exec_tests.svh"

    always @(posedge div_ready) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", max_cycles);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        model_hilo = '0;
        op_valid   = 1'b0;
        op         = add;
        a          = '0;
        b          = '0;
        cp0_data   = '0;
        wait (rst_n === 1'b1);
        @(posedge div_ready);
        check_bit("reset result_valid", 1'b0, result_valid);
        check_bit("reset busy", 1'b0, busy);
        check_hilo("reset hilo", '0, hilo);

        arith_ops();
        logic_ops();
        multiply_ops();
        divide_ops();
        move_ops();

        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- verilog/exec_decode.sv
`timescale 1ns/1ns

module exec_decode import exec_pkg::*; (
    input  logic              div_ready,
    input  logic              rst_n,
    input  logic              op_valid,
    input  alu_op_t           op,
    input  logic [word_w-1:0] a,
    input  logic [word_w-1:0] b,
    output logic              dec_valid,
    output alu_op_t           dec_op,
    output op_class_t         dec_class,
    output logic [word_w-1:0] dec_a,
    output logic [word_w-1:0] dec_b
);

    op_class_t op_class;

    always_comb begin
        case (op)
            mult, multu, mthi, mtlo: op_class = cls_muldiv;
            div, divu:               op_class = cls_div;
            mfhi, mflo, mfc0:        op_class = cls_move;
            default:                 op_class = cls_int;
        endcase
    end

    always_ff @(posedge div_ready or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= op_valid;
        end
    end

    // loaded on issue only, qualified by dec_valid downstream
    always_ff @(posedge div_ready) begin
        if (op_valid) begin
            dec_op    <= op;
            dec_class <= op_class;
            dec_a     <= a;
            dec_b     <= b;
        end
    end

    a_known_op: assert property (@(posedge div_ready) disable iff (!rst_n)
        op_valid |-> !$isunknown(op) && (op <= mfc0))
        else $error("exec_decode: undefined op code %0d issued", op);

endmodule

//--- verilog/exec_pkg.sv
package exec_pkg;

    localparam int word_w  = 32;
    localparam int hilo_w  = 2 * word_w;
    localparam int shamt_w = $clog2(word_w);   // low bits of operand a

    // issue to result_valid for div/divu with 32 divider steps
    localparam int div_latency = 35;

    typedef enum logic [4:0] {
        add    = 5'd0,
        addu   = 5'd1,
        sub    = 5'd2,
        subu   = 5'd3,
        slt    = 5'd4,
        sltu   = 5'd5,
        and_op = 5'd6,
        or_op  = 5'd7,
        nor_op = 5'd8,
        xor_op = 5'd9,
        lui    = 5'd10,
        sll    = 5'd11,
        srl    = 5'd12,
        sra    = 5'd13,
        mult   = 5'd14,
        multu  = 5'd15,
        div    = 5'd16,
        divu   = 5'd17,
        mthi   = 5'd18,
        mtlo   = 5'd19,
        mfhi   = 5'd20,
        mflo   = 5'd21,
        mfc0   = 5'd22     // highest legal code
    } alu_op_t;

    // which stage completes the operation
    typedef enum logic [1:0] {
        cls_int    = 2'd0,   // int_alu
        cls_muldiv = 2'd1,   // mult, multu, mthi, mtlo
        cls_move   = 2'd2,   // mfhi, mflo, mfc0
        cls_div    = 2'd3    // result comes with div_done
    } op_class_t;

endpackage

//--- verilog/exec_top.sv
`timescale 1ns/1ns

module exec_top import exec_pkg::*; #(
    parameter int div_steps = 32
) (
    input  logic              div_ready,
    input  logic              rst_n,
    input  logic              op_valid,
    input  alu_op_t           op,
    input  logic [word_w-1:0] a,
    input  logic [word_w-1:0] b,
    input  logic [word_w-1:0] cp0_data,
    output logic              result_valid,
    output logic [word_w-1:0] result,
    output logic              overflow,
    output logic [hilo_w-1:0] hilo,
    output logic              busy
);

    logic              dec_valid;
    alu_op_t           dec_op;
    op_class_t         dec_class;
    logic [word_w-1:0] dec_a;
    logic [word_w-1:0] dec_b;
    logic [word_w-1:0] alu_result;
    logic              alu_overflow;
    logic [word_w-1:0] move_result;
    logic              div_done;

    exec_decode u_decode (
        .div_ready (div_ready),
        .rst_n     (rst_n),
        .op_valid  (op_valid),
        .op        (op),
        .a         (a),
        .b         (b),
        .dec_valid (dec_valid),
        .dec_op    (dec_op),
        .dec_class (dec_class),
        .dec_a     (dec_a),
        .dec_b     (dec_b)
    );

    int_alu u_alu (
        .dec_op       (dec_op),
        .dec_a        (dec_a),
        .dec_b        (dec_b),
        .alu_result   (alu_result),
        .alu_overflow (alu_overflow)
    );

    muldiv_hilo #(
        .div_steps (div_steps)
    ) u_muldiv (
        .div_ready   (div_ready),
        .rst_n       (rst_n),
        .dec_valid   (dec_valid),
        .dec_op      (dec_op),
        .dec_class   (dec_class),
        .dec_a       (dec_a),
        .dec_b       (dec_b),
        .cp0_data    (cp0_data),
        .move_result (move_result),
        .div_done    (div_done),
        .busy        (busy),
        .hilo        (hilo)
    );

    exec_writeback u_wb (
        .div_ready    (div_ready),
        .rst_n        (rst_n),
        .dec_valid    (dec_valid),
        .dec_class    (dec_class),
        .alu_result   (alu_result),
        .alu_overflow (alu_overflow),
        .move_result  (move_result),
        .div_done     (div_done),
        .result_valid (result_valid),
        .result       (result),
        .overflow     (overflow)
    );

endmodule

//--- verilog/exec_writeback.sv
`timescale 1ns/1ns

module exec_writeback import exec_pkg::*; (
    input  logic              div_ready,
    input  logic              rst_n,
    input  logic              dec_valid,
    input  op_class_t         dec_class,
    input  logic [word_w-1:0] alu_result,
    input  logic              alu_overflow,
    input  logic [word_w-1:0] move_result,
    input  logic              div_done,
    output logic              result_valid,
    output logic [word_w-1:0] result,
    output logic              overflow
);

    logic              wb_valid;
    logic [word_w-1:0] wb_result;
    logic              wb_overflow;

    // a division reports later, on div_done
    assign wb_valid = div_done || (dec_valid && (dec_class != cls_div));

    always_comb begin
        wb_result   = '0;
        wb_overflow = 1'b0;
        if (!div_done) begin
            case (dec_class)
                cls_int: begin
                    wb_result   = alu_result;
                    wb_overflow = alu_overflow;
                end
                cls_move: wb_result = move_result;
                default:  wb_result = '0;   // value goes to hilo
            endcase
        end
    end

    always_ff @(posedge div_ready or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= wb_valid;
        end
    end

    always_ff @(posedge div_ready) begin
        if (wb_valid) begin
            result   <= wb_result;
            overflow <= wb_overflow;
        end
    end

    a_one_source: assert property (@(posedge div_ready) disable iff (!rst_n)
        dec_valid |-> !div_done)
        else $error("exec_writeback: new operation collides with divider result");

endmodule

//--- verilog/int_alu.sv
`timescale 1ns/1ns

module int_alu import exec_pkg::*; (
    input  alu_op_t           dec_op,
    input  logic [word_w-1:0] dec_a,
    input  logic [word_w-1:0] dec_b,
    output logic [word_w-1:0] alu_result,
    output logic              alu_overflow
);

    logic [word_w-1:0]  sum;
    logic [word_w-1:0]  diff;
    logic [shamt_w-1:0] shamt;
    logic               a_neg;
    logic               b_neg;
    logic               add_ovf;
    logic               sub_ovf;

    assign sum   = dec_a + dec_b;
    assign diff  = dec_a - dec_b;
    assign shamt = dec_a[shamt_w-1:0];
    assign a_neg = dec_a[word_w-1];
    assign b_neg = dec_b[word_w-1];

    // same signs in, other sign out
    assign add_ovf = (a_neg == b_neg) && (sum[word_w-1] != a_neg);
    assign sub_ovf = (a_neg != b_neg) && (diff[word_w-1] != a_neg);

    always_comb begin
        alu_result   = '0;
        alu_overflow = 1'b0;
        case (dec_op)
            add: begin
                alu_result   = sum;
                alu_overflow = add_ovf;
            end
            addu:    alu_result = sum;
            sub: begin
                alu_result   = diff;
                alu_overflow = sub_ovf;
            end
            subu:    alu_result = diff;
            slt:     alu_result = {{(word_w-1){1'b0}}, $signed(dec_a) < $signed(dec_b)};
            sltu:    alu_result = {{(word_w-1){1'b0}}, dec_a < dec_b};
            and_op:  alu_result = dec_a & dec_b;
            or_op:   alu_result = dec_a | dec_b;
            nor_op:  alu_result = ~(dec_a | dec_b);
            xor_op:  alu_result = dec_a ^ dec_b;
            lui:     alu_result = {dec_b[word_w/2-1:0], {(word_w/2){1'b0}}};
            sll:     alu_result = dec_b << shamt;
            srl:     alu_result = dec_b >> shamt;
            sra:     alu_result = $signed(dec_b) >>> shamt;   // keeps the sign bit
            default: alu_result = '0;   // completed in another stage
        endcase
    end

endmodule

//--- verilog/muldiv_hilo.sv
`timescale 1ns/1ns

module muldiv_hilo import exec_pkg::*; #(
    parameter int div_steps = 32
) (
    input  logic              div_ready,
    input  logic              rst_n,
    input  logic              dec_valid,
    input  alu_op_t           dec_op,
    input  op_class_t         dec_class,
    input  logic [word_w-1:0] dec_a,
    input  logic [word_w-1:0] dec_b,
    input  logic [word_w-1:0] cp0_data,
    output logic [word_w-1:0] move_result,
    output logic              div_done,
    output logic              busy,
    output logic [hilo_w-1:0] hilo
);

    logic              div_start;
    logic              div_signed;
    logic              div_run;
    logic [word_w-1:0] quotient;
    logic [word_w-1:0] remainder;
    logic [hilo_w-1:0] a_sext;
    logic [hilo_w-1:0] b_sext;
    logic [hilo_w-1:0] prod_s;
    logic [hilo_w-1:0] prod_u;

    assign div_start  = dec_valid && (dec_class == cls_div);
    assign div_signed = (dec_op == div);

    assign a_sext = {{word_w{dec_a[word_w-1]}}, dec_a};
    assign b_sext = {{word_w{dec_b[word_w-1]}}, dec_b};
    assign prod_s = a_sext * b_sext;   // low hilo_w bits are the signed product
    assign prod_u = {{word_w{1'b0}}, dec_a} * {{word_w{1'b0}}, dec_b};

    seq_divider #(
        .div_steps (div_steps)
    ) u_div (
        .div_ready  (div_ready),
        .rst_n      (rst_n),
        .div_start  (div_start),
        .div_signed (div_signed),
        .dividend   (dec_a),
        .divisor    (dec_b),
        .div_done   (div_done),
        .quotient   (quotient),
        .remainder  (remainder)
    );

    // high from the start cycle until the result is written
    always_ff @(posedge div_ready or negedge rst_n) begin
        if (!rst_n) begin
            div_run <= 1'b0;
        end else if (div_start) begin
            div_run <= 1'b1;
        end else if (div_done) begin
            div_run <= 1'b0;
        end
    end

    assign busy = div_start || div_run;

    always_ff @(posedge div_ready or negedge rst_n) begin
        if (!rst_n) begin
            hilo <= '0;
        end else if (div_done) begin
            hilo <= {remainder, quotient};   // hi = rem, lo = quot
        end else if (dec_valid && (dec_class == cls_muldiv)) begin
            case (dec_op)
                mult:    hilo <= prod_s;
                multu:   hilo <= prod_u;
                mthi:    hilo <= {dec_a, hilo[word_w-1:0]};
                mtlo:    hilo <= {hilo[hilo_w-1:word_w], dec_a};
                default: hilo <= hilo;
            endcase
        end
    end

    always_comb begin
        case (dec_op)
            mfhi:    move_result = hilo[hilo_w-1:word_w];
            mflo:    move_result = hilo[word_w-1:0];
            mfc0:    move_result = cp0_data;
            default: move_result = '0;
        endcase
    end

    a_div_not_busy: assert property (@(posedge div_ready) disable iff (!rst_n)
        div_start |-> !div_run)
        else $error("muldiv_hilo: division issued while busy");

endmodule

//--- verilog/seq_divider.sv
`timescale 1ns/1ns

module seq_divider import exec_pkg::*; #(
    parameter int div_steps = 32
) (
    input  logic              div_ready,
    input  logic              rst_n,
    input  logic              div_start,
    input  logic              div_signed,
    input  logic [word_w-1:0] dividend,
    input  logic [word_w-1:0] divisor,
    output logic              div_done,
    output logic [word_w-1:0] quotient,
    output logic [word_w-1:0] remainder
);

    localparam int cnt_w = $clog2(div_steps + 1);

    logic              running;
    logic [cnt_w-1:0]  cnt;
    logic [word_w-1:0] q_r;     // dividend bits out, quotient bits in
    logic [word_w-1:0] rem_r;
    logic [word_w-1:0] dvs_r;
    logic              neg_q;
    logic              neg_r;
    logic              neg_a;
    logic              neg_b;
    logic [word_w-1:0] mag_a;
    logic [word_w-1:0] mag_b;
    logic [word_w:0]   trial;
    logic [word_w:0]   diff;

    assign neg_a = div_signed && dividend[word_w-1];
    assign neg_b = div_signed && divisor[word_w-1];
    assign mag_a = neg_a ? -dividend : dividend;
    assign mag_b = neg_b ? -divisor : divisor;

    // one restoring step
    assign trial = {rem_r, q_r[word_w-1]};
    assign diff  = trial - {1'b0, dvs_r};

    always_ff @(posedge div_ready or negedge rst_n) begin
        if (!rst_n) begin
            running  <= 1'b0;
            div_done <= 1'b0;
            cnt      <= '0;
        end else begin
            div_done <= 1'b0;
            if (div_start) begin
                running <= 1'b1;
                cnt     <= cnt_w'(div_steps);
            end else if (running) begin
                cnt <= cnt - 1'b1;
                if (cnt == cnt_w'(1)) begin   // last step
                    running  <= 1'b0;
                    div_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge div_ready) begin
        if (div_start) begin
            // fewer steps divide only the low div_steps bits
            q_r   <= mag_a << (word_w - div_steps);
            rem_r <= mag_a >> div_steps;
            dvs_r <= mag_b;
            neg_q <= neg_a ^ neg_b;
            neg_r <= neg_a;
        end else if (running) begin
            if (!diff[word_w]) begin
                rem_r <= diff[word_w-1:0];
                q_r   <= {q_r[word_w-2:0], 1'b1};
            end else begin
                rem_r <= trial[word_w-1:0];   // restore
                q_r   <= {q_r[word_w-2:0], 1'b0};
            end
        end
    end

    // sign fix-up, valid in the div_done cycle
    assign quotient  = neg_q ? -q_r : q_r;
    assign remainder = neg_r ? -rem_r : rem_r;   // sign of the dividend

    a_no_restart: assert property (@(posedge div_ready) disable iff (!rst_n)
        div_start |-> !running && !div_done)
        else $error("seq_divider: start while a division is in progress");

endmodule
